//--- basic_organ.f
+incdir+rtl
rtl/organ_pkg.sv
rtl/organ_tone_gen.sv
rtl/speed_ctrl.sv
rtl/seg7_display.sv
rtl/led_chaser.sv
rtl/organ_top.sv
dv/organ_chk.sv
dv/organ_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = organ_tb
FILELIST = basic_organ.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "SIMULATION FAILED" $(LOG); then \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

//--- dv/organ_tb.sv
`include "organ_consts.svh"

module organ_tb;

  typedef struct packed {
    logic                 rnd;
    organ_pkg::note_e     note;
    logic                 en;
    organ_pkg::key_cmd_t  keys;
    int                   cycles;
    int                   steps;
  } test_entry_t;

  logic                                Clock_2Hz;
  logic                                rst_i;
  organ_pkg::note_e                    note_i;
  logic                                audio_en_i;
  organ_pkg::key_cmd_t                 keys_i;
  organ_pkg::audio_sample_t            sample_o;
  organ_pkg::note_name_t               note_name_o;
  organ_pkg::seg_t [`NUM_DIGITS-1:0]   hex_o;
  logic [`LED_WIDTH-1:0]               led_o;

  test_entry_t  table_q[$];
  string        name_q[$];
  int           err_count = 0;
  int           check_count = 0;
  int           pass_tests = 0;
  int           fail_tests = 0;
  int           test_start_errs = 0;
  int           cyc = 0;
  logic [31:0]  lfsr_q = 32'h9cabbb24;

  // LED model state
  int    led_pos = 0;
  int    led_dir = 1;
  logic  led_half = 1'b0;

  // Active-low hex digits, bit 0 is segment a
  logic [6:0]  seg_tab [16] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
                                7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E};
  logic [15:0] name_tab [8] = '{"Do", "Re", "Mi", "Fa", "So", "La", "Si", "DO"};
  int          div_tab [8]  = '{24, 21, 19, 18, 16, 14, 13, 12};

  organ_top organ_top_i (.*);

  initial
  begin
    Clock_2Hz = 1'b0;
    forever #5 Clock_2Hz = ~Clock_2Hz;
  end

  // ==========================================================================
  // Helpers
  // ==========================================================================

  task automatic check_value(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    check_count++;
    if (exp_v !== act_v)
    begin
      err_count++;
      $display("CHECK FAILED %s: expected %0h, actual %0h", name, exp_v, act_v);
    end
  endtask

  task automatic add_test(input string name, input logic rnd, input organ_pkg::note_e note,
                          input logic en, input organ_pkg::key_cmd_t keys,
                          input int cycles, input int steps);
    table_q.push_back(test_entry_t'{rnd: rnd, note: note, en: en, keys: keys,
                                    cycles: cycles, steps: steps});
    name_q.push_back(name);
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic pick_note(output organ_pkg::note_e n);
    logic [2:0] r;
    r = '0;
    repeat (3)
    begin
      lfsr_q = lfsr_next(lfsr_q);
      r = {r[1:0], lfsr_q[0]};
    end
    n = organ_pkg::note_e'(r);
  endtask

  // One step every second cycle, turn around at both ends
  task automatic step_led_model();
    if (led_half)
    begin
      led_pos += led_dir;
      if (led_pos == `LED_WIDTH - 1)
        led_dir = -1;
      else if (led_pos == 0)
        led_dir = 1;
    end
    led_half = ~led_half;
  endtask

  // ==========================================================================
  // Apply one table entry
  // ==========================================================================

  task automatic run_test(input int t);
    test_entry_t               e;
    string                     name;
    int                        last_flip;
    int                        periods;
    int                        errs;
    organ_pkg::audio_sample_t  prev;
    logic [15:0]               exp_cnt;
    logic [23:0]               digits;
    e = table_q[t];
    name = name_q[t];
    last_flip = -1;
    periods = 0;
    prev = sample_o;
    if (e.rnd)
      pick_note(e.note);
    note_i = e.note;
    audio_en_i = e.en;
    keys_i = e.keys;
    repeat (e.cycles)
    begin
      @(negedge Clock_2Hz);
      cyc++;
      step_led_model();
      check_value(name, 32'(1) << led_pos, 32'(led_o));
      check_value(name, 32'(name_tab[e.note]), 32'(note_name_o));
      if (!e.en)
        check_value(name, 32'h0, 32'(sample_o));
      else if (sample_o != 8'h7F && sample_o != 8'h80)
      begin
        err_count++;
        $display("Test %s: sample_o is %h, not a full-scale level", name, sample_o);
      end
      else if (prev != sample_o && prev != 8'h00)
      begin
        // Half period measured between two phase flips
        if (last_flip >= 0)
        begin
          check_value(name, 32'(div_tab[e.note]), 32'(cyc - last_flip));
          periods++;
        end
        last_flip = cyc;
      end
      prev = sample_o;
    end
    // Long enough for two flips, so at least one half period must be seen
    if (e.en && e.cycles > 2 * div_tab[e.note] && periods == 0)
    begin
      err_count++;
      $display("Test %s: sample_o never completed a half period", name);
    end
    exp_cnt = 16'(int'(`SCOPE_COUNT_DEFAULT) + e.steps * int'(`SPEED_STEP));
    digits = {8'h00, exp_cnt};
    for (int i = 0; i < `NUM_DIGITS; i++)
      check_value(name, 32'(seg_tab[digits[4*i +: 4]]), 32'(hex_o[i]));
    errs = err_count - test_start_errs;
    test_start_errs = err_count;
    if (errs == 0)
      pass_tests++;
    else
      fail_tests++;
    $display("%-12s %s  (%0d errors)", name, (errs == 0) ? "ok" : "FAIL", errs);
  endtask

  // ==========================================================================
  // Main sequence
  // ==========================================================================

  initial
  begin
    rst_i = 1'b1;
    note_i = organ_pkg::NOTE_DO;
    audio_en_i = 1'b1;
    keys_i = '0;
    add_test("reset_state", 1'b0, organ_pkg::NOTE_DO, 1'b1, 3'b000, 2, 0);
    for (int n = 0; n < 8; n++)
      add_test($sformatf("tone_%0d", n), 1'b0, organ_pkg::note_e'(n), 1'b1, 3'b000, 60, 0);
    for (int m = 0; m < 4; m++)
      add_test($sformatf("mute_%0d", m), 1'b1, organ_pkg::NOTE_DO, 1'b0, 3'b000, 12, 0);
    add_test("led_bounce", 1'b0, organ_pkg::NOTE_DO, 1'b1, 3'b000, 40, 0);
    // Display lags the offset by two cycles
    add_test("speed_up", 1'b0, organ_pkg::NOTE_DO, 1'b1, 3'b100, 30, 2);
    add_test("speed_hold", 1'b0, organ_pkg::NOTE_DO, 1'b1, 3'b000, 10, 3);
    add_test("speed_down", 1'b0, organ_pkg::NOTE_DO, 1'b1, 3'b010, 50, -1);
    add_test("speed_both", 1'b0, organ_pkg::NOTE_DO, 1'b1, 3'b110, 20, -2);
    add_test("speed_clear", 1'b0, organ_pkg::NOTE_DO, 1'b1, 3'b101, 10, 0);

    repeat (2) @(posedge Clock_2Hz);
    @(negedge Clock_2Hz);
    check_value("reset_state", 32'h1, 32'(led_o));
    check_value("reset_state", 32'h0, 32'(sample_o));
    for (int i = 0; i < `NUM_DIGITS; i++)
      check_value("reset_state", 32'h40, 32'(hex_o[i]));
    rst_i = 1'b0;

    for (int t = 0; t < table_q.size(); t++)
      run_test(t);

    $display("Done: %0d tests passed, %0d failed, %0d checks, %0d errors",
             pass_tests, fail_tests, check_count, err_count);
    if (err_count == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

  // Limit is the table length plus reset and slack
  initial
  begin
    int limit;
    #1;
    limit = 50;
    foreach (table_q[t])
      limit += table_q[t].cycles;
    #(limit * 10);
    $display("Watchdog: run did not finish within %0d cycles", limit);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

//--- dv/organ_chk.sv
`include "organ_consts.svh"

module organ_chk (
  input  logic                      Clock_2Hz,
  input  logic                      rst_i,
  input  logic                      audio_en_i,
  input  organ_pkg::audio_sample_t  sample_o,
  input  logic [`LED_WIDTH-1:0]     led_o
);

  // Exactly one LED lit at all times
  led_one_hot: assert property (@(posedge Clock_2Hz) disable iff (rst_i)
    $onehot(led_o))
    else $error("led_o is not one-hot: %b", led_o);

  // Only silence or the two full-scale levels
  sample_level: assert property (@(posedge Clock_2Hz) disable iff (rst_i)
    sample_o inside {8'h00, 8'h7F, 8'h80})
    else $error("sample_o has an illegal level: %h", sample_o);

  // Muted sample is visible at the following sampling edge
  sample_muted: assert property (@(posedge Clock_2Hz) disable iff (rst_i)
    !audio_en_i |=> sample_o == 8'h00)
    else $error("sample_o is not zero while audio is disabled");

endmodule

bind organ_top organ_chk chk_i (.*);

//--- rtl/organ_top.sv
`include "organ_consts.svh"

module organ_top (
  input  logic                                 Clock_2Hz,
  input  logic                                 rst_i,
  input  organ_pkg::note_e                     note_i,
  input  logic                                 audio_en_i,
  input  organ_pkg::key_cmd_t                  keys_i,
  output organ_pkg::audio_sample_t             sample_o,
  output organ_pkg::note_name_t                note_name_o,
  output organ_pkg::seg_t [`NUM_DIGITS-1:0]    hex_o,
  output logic [`LED_WIDTH-1:0]                led_o
);

  organ_pkg::sample_count_t  sample_count;

  // ==========================================================================
  // Audio path
  // ==========================================================================

  organ_tone_gen tone_gen_i (
    .Clock_2Hz   (Clock_2Hz),
    .rst_i       (rst_i),
    .note_i      (note_i),
    .audio_en_i  (audio_en_i),
    .sample_o    (sample_o),
    .note_name_o (note_name_o)
  );

  // ==========================================================================
  // Speed keys, display and LEDs
  // ==========================================================================

  speed_ctrl speed_ctrl_i (
    .Clock_2Hz      (Clock_2Hz),
    .rst_i          (rst_i),
    .keys_i         (keys_i),
    .sample_count_o (sample_count)
  );

  seg7_display seg7_display_i (
    .Clock_2Hz (Clock_2Hz),
    .rst_i     (rst_i),
    .count_i   (sample_count),
    .hex_o     (hex_o)
  );

  led_chaser led_chaser_i (
    .Clock_2Hz (Clock_2Hz),
    .rst_i     (rst_i),
    .led_o     (led_o)
  );

endmodule

//--- rtl/led_chaser.sv
`include "organ_consts.svh"

module led_chaser (
  input  logic                   Clock_2Hz,
  input  logic                   rst_i,
  output logic [`LED_WIDTH-1:0]  led_o
);

  logic                  half_q;
  logic [`LED_WIDTH-1:0] led_next;
  organ_pkg::led_dir_e   dir_q;

  // Next position in the current direction
  assign led_next = (dir_q == organ_pkg::DIR_UP) ? (led_o << 1) : (led_o >> 1);

  always_ff @(posedge Clock_2Hz)
  begin
    if (rst_i)
    begin
      half_q <= 1'b0;
      led_o  <= `LED_WIDTH'(1);
      dir_q  <= organ_pkg::DIR_UP;
    end
    else
    begin
      // Half-rate toggle, the LED moves on every second edge
      half_q <= ~half_q;
      if (half_q)
      begin
        led_o <= led_next;
        // Turn around once an end LED is lit
        if (led_next[`LED_WIDTH-1])
          dir_q <= organ_pkg::DIR_DOWN;
        else if (led_next[0])
          dir_q <= organ_pkg::DIR_UP;
      end
    end
  end

endmodule

//--- rtl/seg7_display.sv
`include "organ_consts.svh"

module seg7_display (
  input  logic                                 Clock_2Hz,
  input  logic                                 rst_i,
  input  organ_pkg::sample_count_t             count_i,
  output organ_pkg::seg_t [`NUM_DIGITS-1:0]    hex_o
);

  organ_pkg::sample_count_t  count_q;
  logic [`NUM_DIGITS*4-1:0]  digits;

  // Standard hex table, segments active low
  function automatic organ_pkg::seg_t hex_to_seg(input logic [3:0] nib);
    organ_pkg::seg_t seg;
    case (nib)
      4'h0:    seg = 7'h40;
      4'h1:    seg = 7'h79;
      4'h2:    seg = 7'h24;
      4'h3:    seg = 7'h30;
      4'h4:    seg = 7'h19;
      4'h5:    seg = 7'h12;
      4'h6:    seg = 7'h02;
      4'h7:    seg = 7'h78;
      4'h8:    seg = 7'h00;
      4'h9:    seg = 7'h10;
      4'hA:    seg = 7'h08;
      4'hB:    seg = 7'h03;
      4'hC:    seg = 7'h46;
      4'hD:    seg = 7'h21;
      4'hE:    seg = 7'h06;
      default: seg = 7'h0E;
    endcase
    return seg;
  endfunction

  always_ff @(posedge Clock_2Hz)
  begin
    if (rst_i)
      count_q <= '0;
    else
      count_q <= count_i;
  end

  // Upper two digits have no count bits and show zero
  assign digits = {{(`NUM_DIGITS*4-16){1'b0}}, count_q};

  always_comb
  begin
    for (int i = 0; i < `NUM_DIGITS; i++)
    begin
      hex_o[i] = hex_to_seg(digits[4*i +: 4]);
    end
  end

endmodule

//--- rtl/speed_ctrl.sv
`include "organ_consts.svh"

module speed_ctrl (
  input  logic                      Clock_2Hz,
  input  logic                      rst_i,
  input  organ_pkg::key_cmd_t       keys_i,
  output organ_pkg::sample_count_t  sample_count_o
);

  logic [7:0]         win_cnt_q;
  logic               win_hit;
  logic               step_up;
  logic               step_down;
  organ_pkg::speed_t  offset_q;

  // ========================================================================
  // Key sampling window
  // ========================================================================

  assign win_hit = (win_cnt_q == `SPEED_EVENT_PERIOD);

  always_ff @(posedge Clock_2Hz)
  begin
    if (rst_i)
      win_cnt_q <= '0;
    else if (win_hit)
      win_cnt_q <= '0;
    else
      win_cnt_q <= win_cnt_q + 8'd1;
  end

  // Only one key held counts as a step
  assign step_up   = win_hit && keys_i.up && !keys_i.down;
  assign step_down = win_hit && keys_i.down && !keys_i.up;

  // ========================================================================
  // Offset and sampling count
  // ========================================================================

  always_ff @(posedge Clock_2Hz)
  begin
    if (rst_i || keys_i.clear)
      offset_q <= '0;
    else if (step_up)
      offset_q <= offset_q + organ_pkg::speed_t'(`SPEED_STEP);
    else if (step_down)
      offset_q <= offset_q - organ_pkg::speed_t'(`SPEED_STEP);
  end

  // Negative offsets wrap through two's complement, as on the board
  always_ff @(posedge Clock_2Hz)
  begin
    if (rst_i)
      sample_count_o <= `SCOPE_COUNT_DEFAULT;
    else
      sample_count_o <= `SCOPE_COUNT_DEFAULT + organ_pkg::sample_count_t'(offset_q);
  end

endmodule

//--- rtl/organ_tone_gen.sv
`include "organ_consts.svh"

module organ_tone_gen (
  input  logic                      Clock_2Hz,
  input  logic                      rst_i,
  input  organ_pkg::note_e          note_i,
  input  logic                      audio_en_i,
  output organ_pkg::audio_sample_t  sample_o,
  output organ_pkg::note_name_t     note_name_o
);

  organ_pkg::note_e          note_q;
  logic                      note_chg;
  logic [7:0]                div;
  logic [7:0]                div_m1;
  logic [7:0]                half_cnt_q;
  logic                      phase_q;
  logic                      phase_d;
  organ_pkg::audio_sample_t  sample_d;

  // Half-period lookup
  always_comb
  begin
    case (note_i)
      organ_pkg::NOTE_DO:    div = `ORGAN_DIV_DO;
      organ_pkg::NOTE_RE:    div = `ORGAN_DIV_RE;
      organ_pkg::NOTE_MI:    div = `ORGAN_DIV_MI;
      organ_pkg::NOTE_FA:    div = `ORGAN_DIV_FA;
      organ_pkg::NOTE_SO:    div = `ORGAN_DIV_SO;
      organ_pkg::NOTE_LA:    div = `ORGAN_DIV_LA;
      organ_pkg::NOTE_SI:    div = `ORGAN_DIV_SI;
      default:               div = `ORGAN_DIV_DO_HI;
    endcase
  end

  assign div_m1   = div - 8'd1;
  assign note_chg = (note_i != note_q);

  // Phase flips at the end of each half period, counter restarts on a new note
  assign phase_d  = (!note_chg && half_cnt_q == div_m1) ? ~phase_q : phase_q;

  // Sample tracks the next phase so both registers update together
  always_comb
  begin
    if (!audio_en_i)
      sample_d = '0;
    else if (phase_d)
      sample_d = organ_pkg::audio_sample_t'(8'h7F);
    else
      sample_d = organ_pkg::audio_sample_t'(8'h80);
  end

  always_ff @(posedge Clock_2Hz)
  begin
    if (rst_i)
    begin
      note_q     <= organ_pkg::NOTE_DO;
      half_cnt_q <= '0;
      phase_q    <= 1'b0;
      sample_o   <= '0;
    end
    else
    begin
      note_q     <= note_i;
      half_cnt_q <= (note_chg || half_cnt_q == div_m1) ? 8'd0 : half_cnt_q + 8'd1;
      phase_q    <= phase_d;
      sample_o   <= sample_d;
    end
  end

  // Solfege name of the selected note
  always_comb
  begin
    case (note_i)
      organ_pkg::NOTE_DO:    note_name_o = '{first_ch: "D", second_ch: "o"};
      organ_pkg::NOTE_RE:    note_name_o = '{first_ch: "R", second_ch: "e"};
      organ_pkg::NOTE_MI:    note_name_o = '{first_ch: "M", second_ch: "i"};
      organ_pkg::NOTE_FA:    note_name_o = '{first_ch: "F", second_ch: "a"};
      organ_pkg::NOTE_SO:    note_name_o = '{first_ch: "S", second_ch: "o"};
      organ_pkg::NOTE_LA:    note_name_o = '{first_ch: "L", second_ch: "a"};
      organ_pkg::NOTE_SI:    note_name_o = '{first_ch: "S", second_ch: "i"};
      default:               note_name_o = '{first_ch: "D", second_ch: "O"};
    endcase
  end

endmodule

//--- rtl/organ_pkg.sv
package organ_pkg;

  // ========================================================================
  // Tone generator types
  // ========================================================================

  // Switch encoding of the eight notes
  typedef enum logic [2:0] {
    NOTE_DO    = 3'd0,
    NOTE_RE    = 3'd1,
    NOTE_MI    = 3'd2,
    NOTE_FA    = 3'd3,
    NOTE_SO    = 3'd4,
    NOTE_LA    = 3'd5,
    NOTE_SI    = 3'd6,
    NOTE_DO_HI = 3'd7
  } note_e;

  typedef logic signed [7:0] audio_sample_t;

  // Two ASCII characters, first one in the upper byte
  typedef struct packed {
    logic [7:0] first_ch;
    logic [7:0] second_ch;
  } note_name_t;

  // ========================================================================
  // Speed, display and LED types
  // ========================================================================

  typedef logic signed [15:0] speed_t;
  typedef logic [15:0] sample_count_t;

  // Keys already inverted to active high
  typedef struct packed {
    logic up;
    logic down;
    logic clear;
  } key_cmd_t;

  // Active low, bit 0 is segment a
  typedef logic [6:0] seg_t;

  typedef enum logic {
    DIR_UP   = 1'b0,
    DIR_DOWN = 1'b1
  } led_dir_e;

endpackage

//--- rtl/organ_consts.svh
`ifndef ORGAN_CONSTS_SVH
`define ORGAN_CONSTS_SVH

// ==========================================================================
// Note half-period divisors
// ==========================================================================

// Clock cycles per half period, scaled down for short simulations
`define ORGAN_DIV_DO     8'd24
`define ORGAN_DIV_RE     8'd21
`define ORGAN_DIV_MI     8'd19
`define ORGAN_DIV_FA     8'd18
`define ORGAN_DIV_SO     8'd16
`define ORGAN_DIV_LA     8'd14
`define ORGAN_DIV_SI     8'd13
`define ORGAN_DIV_DO_HI  8'd12

// ==========================================================================
// Speed control
// ==========================================================================

// Offset change per accepted up or down event
`define SPEED_STEP           16'd100

// Key window is this value plus one cycles
`define SPEED_EVENT_PERIOD   8'd9

// Sampling count with zero offset
`define SCOPE_COUNT_DEFAULT  16'd12499

// ==========================================================================
// Display and LEDs
// ==========================================================================

`define NUM_DIGITS  6
`define LED_WIDTH   8

`endif
